//--- Makefile
# Verilator build and run of the gamma block testbench

TOP = sens_gamma_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f sens_gamma_top.f \
		--top-module $(TOP) -Mdir obj_dir -o sim

# pass or fail comes from the log, not the simulator exit code
run: compile
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Simulation completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- rtl/cmd_deser.sv
module cmd_deser (
    input  logic                  rst,
    input  logic                  mclk,
    input  gamma_pkg::cmd_byte_t  cmd_ad,
    input  logic                  cmd_stb,
    output gamma_pkg::cmd_write_t cmd_write
);
    import gamma_pkg::*;

    deser_state_e         state;
    logic [CMD_CNT_W-1:0] cnt;        // bytes received so far
    cmd_addr_t            addr_r;     // {ah, al}
    cmd_data_t            data_r;     // d3 ends up in the top byte
    logic                 we_r;
    logic                 last_byte;  // sixth byte on the bus now
    logic                 addr_hit;

    // a strobe always restarts, so it never counts as the last byte
    assign last_byte = (state == collect) && !cmd_stb &&
                       (cnt == CMD_CNT_W'(CMD_BYTES - 1));

    // only bits under the mask take part in the compare
    assign addr_hit = ((addr_r ^ GAMMA_BASE_ADDR) & GAMMA_ADDR_MASK) == '0;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            state <= idle;
            cnt   <= '0;
            we_r  <= 1'b0;
        end else begin
            we_r <= last_byte && addr_hit;          // single cycle pulse
            if (cmd_stb) begin
                state <= collect;                   // first byte comes with strobe
                cnt   <= CMD_CNT_W'(1);
            end else if (state == collect) begin
                cnt <= cnt + 1'b1;
                if (last_byte) begin
                    state <= idle;
                end
            end
        end
    end

    // address and payload bytes, no reset needed
    always_ff @(posedge rst) begin
        if (cmd_stb) begin
            addr_r[7:0] <= cmd_ad;                  // address low
        end else if (state == collect) begin
            if (cnt == CMD_CNT_W'(1)) begin
                addr_r[15:8] <= cmd_ad;             // address high
            end else begin
                data_r <= {cmd_ad, data_r[CMD_DATA_W-1:CMD_BYTE_W]};  // d0 first
            end
        end
    end

    // addr_r and data_r hold still through the we cycle
    assign cmd_write.we   = we_r;
    assign cmd_write.sel  = reg_sel_t'(addr_r[1:0]);
    assign cmd_write.data = data_r;

endmodule

//--- rtl/frame_gate.sv
module frame_gate (
    input  logic                   rst,
    input  logic                   mclk,
    input  gamma_pkg::gamma_mode_t mode,
    input  logic                   sof_in,
    input  logic                   eof_in,
    input  logic                   hact_in,
    input  logic                   trig,
    output logic                   sof_pass,
    output logic                   frame_run
);
    import gamma_pkg::*;

    logic vblank;     // from sof up to the first hact
    logic pend_trig;  // trigger waiting for the next sof
    logic trig_ok;    // trigger counts only outside vblank

    assign trig_ok = trig && !vblank;

    // same cycle as sof_in, nothing registered on this path
    assign sof_pass = sof_in && mode.en_input && (pend_trig || mode.repeat_mode);

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            vblank    <= 1'b0;
            pend_trig <= 1'b0;
            frame_run <= 1'b0;
        end else begin
            // sof opens the blank, first active line closes it
            vblank <= sof_in || (vblank && !hact_in);

            // any sof consumes the pending trigger, passed or not
            pend_trig <= trig_ok || (pend_trig && !sof_in);

            // running from a passed sof until eof
            frame_run <= sof_pass || (frame_run && !eof_in);
        end
    end

endmodule

//--- rtl/gamma_interp.sv
module gamma_interp (
    input  logic                   rst,
    input  logic                   mclk,
    input  gamma_pkg::gamma_mode_t mode,
    input  logic                   frame_run,
    input  logic                   sof_pass,
    input  gamma_pkg::pixel_in_t   pxd_in,
    input  logic                   hact_in,
    input  logic                   eof_in,
    output gamma_pkg::table_addr_t raddr,
    output logic                   ren,
    input  gamma_pkg::table_word_t rdata,
    output gamma_pkg::pixel_out_t  pxd_out,
    output logic                   hact_out,
    output logic                   sof_out,
    output logic                   eof_out
);
    import gamma_pkg::*;

    logic [3:0] hact_d;                  // sync delay lines, 4 cycles
    logic [3:0] sof_d;
    logic [3:0] eof_d;

    logic   line_start;                  // first pixel of a line
    logic   line_seen;                   // a line already started in this frame
    logic   row_r;                       // color bit 1 of the current line
    logic   col0_r;                      // color bit 0 of the next pixel
    logic   b0_r;                        // bayer[0] latched before the frame
    logic   cur_b0;
    logic   cur_b1;
    bayer_t color;

    logic [TABLE_DIFF_W-1:0] diff_w;     // raw table fields
    logic [TABLE_BASE_W-1:0] base_w;
    logic signed [10:0]      diff_dec;   // decoded slope
    logic signed [10:0]      diff_r;     // stage 2
    logic [TABLE_BASE_W-1:0] base_r;
    logic [7:0]              lo_d1;      // pixel low byte, stage 1
    logic [7:0]              lo_d2;      // stage 2, meets diff_r
    logic signed [19:0]      prod;
    logic [17:7]             prod_r;     // stage 3, bit 7 kept for rounding
    logic [TABLE_BASE_W-1:0] base_r2;
    logic [TABLE_BASE_W-1:0] sum;

    // color tracking
    assign line_start = hact_in && !hact_d[0];
    assign cur_b0     = line_start ? b0_r : col0_r;
    assign cur_b1     = (line_start && line_seen) ? !row_r : row_r;  // flip on later lines
    assign color      = frame_run ? {cur_b1, cur_b0} : mode.bayer;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            line_seen <= 1'b0;
            row_r     <= 1'b0;
            col0_r    <= 1'b0;
            b0_r      <= 1'b0;
        end else if (!frame_run) begin
            line_seen <= 1'b0;                  // reload from mode between frames
            row_r     <= mode.bayer[1];
            col0_r    <= mode.bayer[0];
            b0_r      <= mode.bayer[0];
        end else if (hact_in) begin
            line_seen <= 1'b1;
            row_r     <= cur_b1;
            col0_r    <= !cur_b0;               // alternate along the line
        end
    end

    // table lookup, data back next cycle
    assign raddr = {mode.table_page, color, pxd_in[15:8]};
    assign ren   = hact_in;

    assign diff_w = rdata[TABLE_WORD_W-1 -: TABLE_DIFF_W];
    assign base_w = rdata[TABLE_BASE_W-1:0];

    // msb set: coarse slope, 7 bits scaled by 16
    assign diff_dec = diff_w[7] ? {diff_w[6:0], 4'b0000} :
                                  {{4{diff_w[6]}}, diff_w[6:0]};

    assign prod = diff_r * $signed({1'b0, lo_d2});  // signed x positive
    assign sum  = base_r2 + prod_r[17:8] + TABLE_BASE_W'(prod_r[7]);

    // datapath registers, no reset
    always_ff @(posedge rst) begin
        lo_d1   <= pxd_in[7:0];
        lo_d2   <= lo_d1;
        diff_r  <= diff_dec;
        base_r  <= base_w;
        prod_r  <= prod[17:7];
        base_r2 <= base_r;
        pxd_out <= sum[TABLE_BASE_W-1 -: PIXEL_OUT_W];  // drop 2 extra bits
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            hact_d <= '0;
            sof_d  <= '0;
            eof_d  <= '0;
        end else begin
            hact_d <= {hact_d[2:0], hact_in};
            sof_d  <= {sof_d[2:0], sof_pass};   // only passed frames show up
            eof_d  <= {eof_d[2:0], eof_in};
        end
    end

    assign hact_out = hact_d[3];
    assign sof_out  = sof_d[3];
    assign eof_out  = eof_d[3];

endmodule

//--- rtl/gamma_pkg.sv
package gamma_pkg;

    // command port decoding
    localparam logic [15:0] GAMMA_BASE_ADDR = 16'h338;  // block base address
    localparam logic [15:0] GAMMA_ADDR_MASK = 16'h3fc;  // low 2 bits pick the register
    localparam logic [1:0]  REG_CTRL        = 2'd0;     // mode register
    localparam logic [1:0]  REG_TADDR       = 2'd2;     // table address load
    localparam logic [1:0]  REG_TDATA       = 2'd3;     // table data, auto-increments address
    localparam int          CMD_BYTES       = 6;        // al, ah, d0..d3
    localparam int          CMD_CNT_W       = $clog2(CMD_BYTES);

    // widths
    localparam int CMD_BYTE_W   = 8;
    localparam int CMD_ADDR_W   = 16;
    localparam int CMD_DATA_W   = 32;
    localparam int PIXEL_IN_W   = 16;
    localparam int PIXEL_OUT_W  = 8;
    localparam int TABLE_ADDR_W = 11;                   // page, color, pixel high byte
    localparam int TABLE_DEPTH  = 1 << TABLE_ADDR_W;
    localparam int TABLE_BASE_W = 10;                   // 2 bits more than the output
    localparam int TABLE_DIFF_W = 8;                    // encoded slope to next point
    localparam int TABLE_WORD_W = TABLE_DIFF_W + TABLE_BASE_W;

    typedef logic [CMD_BYTE_W-1:0]   cmd_byte_t;
    typedef logic [CMD_ADDR_W-1:0]   cmd_addr_t;
    typedef logic [CMD_DATA_W-1:0]   cmd_data_t;
    typedef logic [1:0]              reg_sel_t;
    typedef logic [PIXEL_IN_W-1:0]   pixel_in_t;
    typedef logic [PIXEL_OUT_W-1:0]  pixel_out_t;
    typedef logic [TABLE_ADDR_W-1:0] table_addr_t;
    typedef logic [TABLE_WORD_W-1:0] table_word_t;
    typedef logic [1:0]              bayer_t;

    // ctrl register layout, lsb first: bayer[1:0], page, en, repeat
    typedef struct packed {
        logic   repeat_mode;  // pass every sof, no trigger needed
        logic   en_input;     // 0 blocks all frames
        logic   table_page;   // selects one of two table pages
        bayer_t bayer;        // color of first pixel in a frame
    } gamma_mode_t;

    // one decoded host write
    typedef struct packed {
        logic      we;
        reg_sel_t  sel;
        cmd_data_t data;
    } cmd_write_t;

    // one table word write
    typedef struct packed {
        logic        we;
        table_addr_t addr;
        table_word_t data;
    } table_write_t;

    typedef enum logic {
        idle,     // waiting for strobe
        collect   // strobe seen, gathering bytes
    } deser_state_e;

endpackage

//--- rtl/gamma_regs.sv
module gamma_regs (
    input  logic                    rst,
    input  logic                    mclk,
    input  gamma_pkg::cmd_write_t   cmd_write,
    output gamma_pkg::gamma_mode_t  mode,
    output gamma_pkg::table_write_t table_write
);
    import gamma_pkg::*;

    table_addr_t taddr;      // next table word to write
    logic        set_ctrl;
    logic        set_taddr;
    logic        set_tdata;

    // select 1 has no register behind it
    assign set_ctrl  = cmd_write.we && (cmd_write.sel == REG_CTRL);
    assign set_taddr = cmd_write.we && (cmd_write.sel == REG_TADDR);
    assign set_tdata = cmd_write.we && (cmd_write.sel == REG_TDATA);

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            mode  <= '0;                            // input disabled after reset
            taddr <= '0;
        end else begin
            if (set_ctrl) begin
                mode <= gamma_mode_t'(cmd_write.data[$bits(gamma_mode_t)-1:0]);
            end
            if (set_taddr) begin
                taddr <= cmd_write.data[TABLE_ADDR_W-1:0];
            end else if (set_tdata) begin
                taddr <= taddr + 1'b1;              // step after each data word
            end
        end
    end

    // word goes to the current address in the same cycle
    assign table_write.we   = set_tdata;
    assign table_write.addr = taddr;
    assign table_write.data = cmd_write.data[TABLE_WORD_W-1:0];  // {diff, base}

endmodule

//--- rtl/gamma_table_ram.sv
module gamma_table_ram (
    input  logic                    rst,
    input  logic                    mclk,
    input  gamma_pkg::table_write_t table_write,
    input  gamma_pkg::table_addr_t  raddr,
    input  logic                    ren,
    output gamma_pkg::table_word_t  rdata
);
    import gamma_pkg::*;

    table_word_t mem [TABLE_DEPTH];  // 4 colors x 2 pages x 256 points

    // host side write port
    always_ff @(posedge rst) begin
        if (table_write.we) begin
            mem[table_write.addr] <= table_write.data;
        end
    end

    // pixel side read, holds last word while ren low
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- rtl/sens_gamma_top.sv
module sens_gamma_top (
    input  logic                  rst,
    input  logic                  mclk,
    input  gamma_pkg::cmd_byte_t  cmd_ad,
    input  logic                  cmd_stb,
    input  gamma_pkg::pixel_in_t  pxd_in,
    input  logic                  hact_in,
    input  logic                  sof_in,
    input  logic                  eof_in,
    input  logic                  trig,
    output gamma_pkg::pixel_out_t pxd_out,
    output logic                  hact_out,
    output logic                  sof_out,
    output logic                  eof_out
);
    import gamma_pkg::*;

    cmd_write_t   cmd_write;    // deser -> regs
    gamma_mode_t  mode;         // ctrl register
    table_write_t table_write;  // regs -> ram
    table_addr_t  raddr;
    logic         ren;
    table_word_t  rdata;
    logic         sof_pass;
    logic         frame_run;

    cmd_deser cmd_deser_inst (
        .rst       (rst),
        .mclk      (mclk),
        .cmd_ad    (cmd_ad),
        .cmd_stb   (cmd_stb),
        .cmd_write (cmd_write)
    );

    gamma_regs gamma_regs_inst (
        .rst         (rst),
        .mclk        (mclk),
        .cmd_write   (cmd_write),
        .mode        (mode),
        .table_write (table_write)
    );

    gamma_table_ram gamma_table_ram_inst (
        .rst         (rst),
        .mclk        (mclk),
        .table_write (table_write),
        .raddr       (raddr),
        .ren         (ren),
        .rdata       (rdata)
    );

    frame_gate frame_gate_inst (
        .rst       (rst),
        .mclk      (mclk),
        .mode      (mode),
        .sof_in    (sof_in),
        .eof_in    (eof_in),
        .hact_in   (hact_in),
        .trig      (trig),
        .sof_pass  (sof_pass),
        .frame_run (frame_run)
    );

    gamma_interp gamma_interp_inst (
        .rst       (rst),
        .mclk      (mclk),
        .mode      (mode),
        .frame_run (frame_run),
        .sof_pass  (sof_pass),
        .pxd_in    (pxd_in),
        .hact_in   (hact_in),
        .eof_in    (eof_in),
        .raddr     (raddr),
        .ren       (ren),
        .rdata     (rdata),
        .pxd_out   (pxd_out),
        .hact_out  (hact_out),
        .sof_out   (sof_out),
        .eof_out   (eof_out)
    );

endmodule

//--- sens_gamma_top.f
+incdir+tb
rtl/gamma_pkg.sv
rtl/cmd_deser.sv
rtl/gamma_regs.sv
rtl/gamma_table_ram.sv
rtl/frame_gate.sv
rtl/gamma_interp.sv
rtl/sens_gamma_top.sv
tb/sens_gamma_tb.sv

//--- tb/sens_gamma_vectors.svh
// one call per scenario, columns in order:
// name, ctrl address, mode {repeat, en, page, bayer}, trigger, frames, lines, pixels,
// low byte forced to 0, sof_out pulses expected over the scenario
task automatic fill_vectors();
    add_row("input_disabled",   16'h0338, 5'b00000, trig_none,   1, 2, 8,  1'b0, 0);
    add_row("base_page0_b0",    16'h0338, 5'b11000, trig_none,   1, 4, 16, 1'b1, 1);
    add_row("base_page0_b3",    16'h0338, 5'b11011, trig_none,   1, 4, 16, 1'b1, 1);
    add_row("interp_b1",        16'h0338, 5'b11001, trig_none,   2, 3, 12, 1'b0, 2);
    add_row("interp_b2",        16'h0338, 5'b11010, trig_none,   2, 3, 12, 1'b0, 2);
    add_row("interp_b3",        16'h0338, 5'b11011, trig_none,   1, 5, 10, 1'b0, 1);
    add_row("base_page1_b1",    16'h0338, 5'b11101, trig_none,   1, 4, 16, 1'b1, 1);
    add_row("interp_page1_b2",  16'h0338, 5'b11110, trig_none,   2, 3, 20, 1'b0, 2);
    add_row("trig_before_sof",  16'h0338, 5'b01000, trig_pre,    2, 2, 8,  1'b0, 2);
    add_row("trig_in_vblank",   16'h0338, 5'b01001, trig_vblank, 2, 2, 8,  1'b0, 0);
    // trigger after the lines arms the next frame, last one stays pending
    add_row("trig_after_lines", 16'h0338, 5'b01010, trig_late,   3, 2, 8,  1'b0, 2);
    // miss keeps trigger mode, leftover trigger passes only the first frame
    add_row("addr_miss_ctrl",   16'h033c, 5'b00000, trig_none,   2, 2, 8,  1'b0, 1);
    add_row("addr_alias_ctrl",  16'h1338, 5'b11100, trig_none,   2, 3, 8,  1'b0, 2);
endtask

//--- tb/sens_gamma_tb.sv
module sens_gamma_tb;
    import gamma_pkg::*;

    typedef enum logic [1:0] {
        trig_none,    // no trigger in the frame
        trig_pre,     // in the gap before sof
        trig_vblank,  // between sof and first line
        trig_late     // after the last line, before eof
    } trig_e;

    typedef struct packed {
        logic [15:0] ctrl_addr;  // address used for the mode write
        gamma_mode_t mode;
        trig_e       trig;
        logic [3:0]  frames;
        logic [3:0]  lines;
        logic [7:0]  pixels;     // per line
        logic        lo_zero;    // pixel low byte forced to 0
        logic [3:0]  exp_sof;    // sof_out pulses over the row
    } row_t;

    typedef struct packed {
        logic       hact;
        logic       sof;
        logic       eof;
        pixel_out_t pix;
    } exp_out_t;

    logic        rst;            // clock
    logic        mclk;           // reset
    cmd_byte_t   cmd_ad;
    logic        cmd_stb;
    pixel_in_t   pxd_in;
    logic        hact_in;
    logic        sof_in;
    logic        eof_in;
    logic        trig;
    pixel_out_t  pxd_out;
    logic        hact_out;
    logic        sof_out;
    logic        eof_out;

    row_t        rows[$];
    string       row_names[$];
    exp_out_t    exp_q[$];                 // 4 deep, one entry per cycle
    table_word_t table_m [TABLE_DEPTH];    // model table
    table_addr_t taddr_m;
    gamma_mode_t mode_m;
    logic        vblank_m;
    logic        pend_m;
    logic        run_m;
    logic        prev_hact_m;
    int          line_m;                   // line index in running frame
    int          pix_m;                    // pixel index in line
    logic [31:0] lcg_state;
    string       cur_name;
    int          cycle_cnt;
    int          cycle_limit;
    int          pix_errors;
    int          flag_errors;
    int          count_errors;
    int          sof_seen;

    sens_gamma_top sens_gamma_top_inst (
        .rst      (rst),
        .mclk     (mclk),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .pxd_in   (pxd_in),
        .hact_in  (hact_in),
        .sof_in   (sof_in),
        .eof_in   (eof_in),
        .trig     (trig),
        .pxd_out  (pxd_out),
        .hact_out (hact_out),
        .sof_out  (sof_out),
        .eof_out  (eof_out)
    );

    always #50 rst = ~rst;

    always @(posedge rst) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected output from one table word and the pixel low byte
    function automatic pixel_out_t interp(table_word_t w, logic [7:0] lo);
        logic [7:0]  diff;
        logic [9:0]  base;
        int          slope;
        logic [31:0] prod;
        logic [9:0]  sum;
        diff  = w[17:10];
        base  = w[9:0];
        slope = diff[7] ? 16 * int'($signed(diff[6:0])) : int'($signed(diff[6:0]));
        prod  = slope * int'(lo);
        sum   = base + prod[17:8] + {9'd0, prod[7]};  // bit 7 rounds
        return sum[9:2];
    endfunction

    task automatic check_pixel(string what, pixel_out_t exp, pixel_out_t act);
        if (act !== exp) begin
            pix_errors++;
            $display("** Error: %s %s expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("** Error: %s %s expected %b actual %b", cur_name, what, exp, act);
        end
    endtask

    task automatic check_count(string what, int exp, int act);
        if (act != exp) begin
            count_errors++;
            $display("** Error: %s %s expected %0d actual %0d", cur_name, what, exp, act);
        end
    endtask

    // one cycle: check outputs of 4 cycles ago, drive inputs, step the model
    task automatic tick(logic stb, cmd_byte_t byte_v, pixel_in_t px, logic hact,
                        logic sof, logic eof, logic trg);
        exp_out_t    old_e;
        exp_out_t    new_e;
        bayer_t      color;
        logic        sof_ok;
        table_word_t w;
        @(negedge rst);
        if (exp_q.size() == 4) begin
            old_e = exp_q.pop_front();
            check_flag("hact_out", old_e.hact, hact_out);
            check_flag("sof_out", old_e.sof, sof_out);
            check_flag("eof_out", old_e.eof, eof_out);
            if (old_e.hact) begin
                check_pixel("pxd_out", old_e.pix, pxd_out);
            end
            if (sof_out === 1'b1) begin
                sof_seen++;
            end
        end
        cmd_stb = stb;
        cmd_ad  = byte_v;
        pxd_in  = px;
        hact_in = hact;
        sof_in  = sof;
        eof_in  = eof;
        trig    = trg;
        sof_ok = sof && mode_m.en_input && (pend_m || mode_m.repeat_mode);
        color  = mode_m.bayer;                           // outside a running frame
        if (run_m && hact) begin
            if (!prev_hact_m) begin
                line_m++;                                // new line
                pix_m = 0;
            end
            color = {mode_m.bayer[1] ^ line_m[0], mode_m.bayer[0] ^ pix_m[0]};
            pix_m++;
        end
        w = table_m[{mode_m.table_page, color, px[15:8]}];
        new_e.hact = hact;
        new_e.sof  = sof_ok;
        new_e.eof  = eof;
        new_e.pix  = interp(w, px[7:0]);
        exp_q.push_back(new_e);
        pend_m   = (trg && !vblank_m) || (pend_m && !sof);  // vblank triggers ignored
        vblank_m = sof || (vblank_m && !hact);
        if (!run_m) begin
            line_m = -1;
        end
        run_m       = sof_ok || (run_m && !eof);
        prev_hact_m = hact;
    endtask

    task automatic idle(int n);
        repeat (n) tick(1'b0, 8'h00, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    function automatic logic [15:0] reg_addr(reg_sel_t sel);
        return {GAMMA_BASE_ADDR[15:2], sel};
    endfunction

    // six bytes, strobe on the first, then update the model if it hits
    task automatic send_cmd(logic [15:0] addr, cmd_data_t data);
        logic hit;
        hit = (addr & GAMMA_ADDR_MASK) == (GAMMA_BASE_ADDR & GAMMA_ADDR_MASK);
        tick(1'b1, addr[7:0], '0, 1'b0, 1'b0, 1'b0, 1'b0);
        tick(1'b0, addr[15:8], '0, 1'b0, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            tick(1'b0, data[8*i +: 8], '0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        if (hit) begin
            case (addr[1:0])
                REG_CTRL:  mode_m = gamma_mode_t'(data[4:0]);
                REG_TADDR: taddr_m = data[10:0];
                REG_TDATA: begin
                    table_m[taddr_m] = data[17:0];
                    taddr_m++;                           // auto-increment
                end
                default: ;
            endcase
        end
    endtask

    // gap, sof, vblank, lines with hblank, eof
    task automatic run_frame(row_t r);
        pixel_in_t px;
        idle(1);
        tick(1'b0, 8'h00, '0, 1'b0, 1'b0, 1'b0, r.trig == trig_pre);
        idle(2);
        tick(1'b0, 8'h00, '0, 1'b0, 1'b1, 1'b0, 1'b0);
        idle(1);
        tick(1'b0, 8'h00, '0, 1'b0, 1'b0, 1'b0, r.trig == trig_vblank);
        idle(1);
        for (int l = 0; l < r.lines; l++) begin
            for (int p = 0; p < r.pixels; p++) begin
                px = pixel_in_t'(lcg_next() >> 12);
                if (r.lo_zero) begin
                    px[7:0] = 8'h00;                     // result is the base
                end
                tick(1'b0, 8'h00, px, 1'b1, 1'b0, 1'b0, 1'b0);
            end
            tick(1'b0, 8'h00, '0, 1'b0, 1'b0, 1'b0,
                 (r.trig == trig_late) && (l == r.lines - 1));
            idle(2);
        end
        tick(1'b0, 8'h00, '0, 1'b0, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic add_row(string name, logic [15:0] addr, logic [4:0] mode, trig_e trg,
                           int frames, int lines, int pixels, logic lo_zero, int exp_sof);
        row_t r;
        r.ctrl_addr = addr;
        r.mode      = gamma_mode_t'(mode);
        r.trig      = trg;
        r.frames    = 4'(frames);
        r.lines     = 4'(lines);
        r.pixels    = 8'(pixels);
        r.lo_zero   = lo_zero;
        r.exp_sof   = 4'(exp_sof);
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    `include "sens_gamma_vectors.svh"

    initial begin
        int total;
        rst = 1'b0;
        mclk = 1'b1;
        cmd_ad = '0;
        cmd_stb = 1'b0;
        pxd_in = '0;
        hact_in = 1'b0;
        sof_in = 1'b0;
        eof_in = 1'b0;
        trig = 1'b0;
        lcg_state = 32'h455b;
        mode_m = '0;
        taddr_m = '0;
        vblank_m = 1'b0;
        pend_m = 1'b0;
        run_m = 1'b0;
        prev_hact_m = 1'b0;
        line_m = -1;
        pix_m = 0;
        pix_errors = 0;
        flag_errors = 0;
        count_errors = 0;
        sof_seen = 0;
        cycle_cnt = 0;
        cur_name = "table_load";
        fill_vectors();
        total = 4 + 6 * (TABLE_DEPTH + 1) + 8;           // reset, table load, drain
        foreach (rows[i]) begin
            total += 12 + rows[i].frames * (9 + rows[i].lines * (rows[i].pixels + 3));
        end
        cycle_limit = total + total / 4 + 100;
        idle(4);
        mclk = 1'b0;
        send_cmd(reg_addr(REG_TADDR), 32'h0);            // address set once
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            send_cmd(reg_addr(REG_TDATA), lcg_next());   // only low 18 bits kept
        end
        foreach (rows[i]) begin
            cur_name = row_names[i];
            sof_seen = 0;
            send_cmd(rows[i].ctrl_addr, {27'd0, rows[i].mode});
            for (int f = 0; f < rows[i].frames; f++) begin
                run_frame(rows[i]);
            end
            idle(6);                                     // let the last sync drain
            check_count("sof_out pulses", rows[i].exp_sof, sof_seen);
        end
        idle(8);
        $display("errors: pixel %0d, flag %0d, count %0d",
                 pix_errors, flag_errors, count_errors);
        if (pix_errors + flag_errors + count_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
